// File: rvCore_params.svh
// Global sizing and reset values for the multicycle RV32I core.
// Included by the package and by any module that sizes storage or sets the PC.
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

// File: rvCorePkg.sv
// Shared types for the multicycle core: field widths, opcodes, mux selects,
// controller states and the structs passed between decoder, controller and datapath.
`include "rvCore_params.svh"

package rvCorePkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

	typedef logic [6:0] opcode_t;
	localparam opcode_t RType      = 7'b0110011;
	localparam opcode_t ITypeLogic = 7'b0010011;
	localparam opcode_t ITypeLoad  = 7'b0000011;
	localparam opcode_t SType      = 7'b0100011;
	localparam opcode_t BType      = 7'b1100011;
	localparam opcode_t JType      = 7'b1101111;

	// op class from the controller, refined by the ALU decoder
	typedef logic [1:0] aluOp_t;
	localparam aluOp_t AluOpAdd   = 2'b00;
	localparam aluOp_t AluOpSub   = 2'b01;
	localparam aluOp_t AluOpRFunc = 2'b10;
	localparam aluOp_t AluOpIFunc = 2'b11;

	typedef logic [2:0] aluCtrl_t;
	localparam aluCtrl_t AluAdd = 3'b000;
	localparam aluCtrl_t AluSub = 3'b001;
	localparam aluCtrl_t AluAnd = 3'b010;
	localparam aluCtrl_t AluOr  = 3'b011;
	localparam aluCtrl_t AluSlt = 3'b101;

	typedef logic [1:0] aluSrcA_t;
	localparam aluSrcA_t SrcAPc    = 2'd0;
	localparam aluSrcA_t SrcAOldPc = 2'd1;
	localparam aluSrcA_t SrcARs1   = 2'd2;

	typedef logic [1:0] aluSrcB_t;
	localparam aluSrcB_t SrcBRs2  = 2'd0;
	localparam aluSrcB_t SrcBImm  = 2'd1;
	localparam aluSrcB_t SrcBFour = 2'd2;

	typedef logic [1:0] resultSrc_t;
	localparam resultSrc_t ResultAluOut = 2'd0;
	localparam resultSrc_t ResultData   = 2'd1;
	localparam resultSrc_t ResultAlu    = 2'd2;

	typedef logic adrSrc_t;
	localparam adrSrc_t AdrPc     = 1'b0;
	localparam adrSrc_t AdrResult = 1'b1;

	typedef enum logic [3:0] {
		Fetch, Decode, ExecuteR, ExecuteI, UncondJump, MemAdr,
		AluWb, MemWrite, MemRead, MemWb, BranchIfEq
	} ctrlState_t;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic [2:0] funct3;
		logic funct7b5;
		word_t imm;
	} decodedInstr_t;

	typedef struct packed {
		adrSrc_t adrSrc;
		logic irWrite;
		logic regWrite;
		logic pcUpdate;
		logic pcSrcJump;
		logic memWrite;
		aluSrcA_t aluSrcA;
		aluSrcB_t aluSrcB;
		aluOp_t aluOp;
		resultSrc_t resultSrc;
	} ctrlSignals_t;

endpackage

// File: instrDecoder.sv
// Instruction register plus field split and immediate generation.
// Loads from the memory bus in the fetch cycle and holds the instruction until the next one.
`timescale 1ns/1ps

module instrDecoder (
	input logic clk,
	input logic reset,
	input logic irWrite,
	input rvCorePkg::word_t instrWord,
	output rvCorePkg::decodedInstr_t decoded
);

	rvCorePkg::word_t ir;

	// instruction register, loaded in fetch
	always_ff @(posedge clk) begin
		if (reset)
			ir <= '0;
		else if (irWrite)
			ir <= instrWord;
	end

	always_comb begin
		decoded.opcode = ir[6:0];
		decoded.rd = ir[11:7];
		decoded.funct3 = ir[14:12];
		decoded.rs1 = ir[19:15];
		decoded.rs2 = ir[24:20];
		decoded.funct7b5 = ir[30];

		case (ir[6:0])
			rvCorePkg::ITypeLogic,
			rvCorePkg::ITypeLoad:
				decoded.imm = {{20{ir[31]}}, ir[31:20]};
			rvCorePkg::SType:
				decoded.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			rvCorePkg::BType:
				decoded.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			rvCorePkg::JType:
				decoded.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			// R-type and unknown opcodes carry no immediate
			default:
				decoded.imm = '0;
		endcase
	end

endmodule

// File: controlFsm.sv
// Moore controller that steps each instruction through fetch, decode and execute states.
// Outputs come from the state alone, apart from the beq PC load which follows the zero flag.
`timescale 1ns/1ps

module controlFsm (
	input logic clk,
	input logic reset,
	input rvCorePkg::opcode_t opcode,
	input logic zeroFlag,
	output rvCorePkg::ctrlSignals_t ctrl,
	output logic halted
);

	rvCorePkg::ctrlState_t state;
	rvCorePkg::ctrlState_t nextState;
	logic knownOp;

	always_ff @(posedge clk) begin
		if (reset)
			state <= rvCorePkg::Fetch;
		else
			state <= nextState;
	end

	assign knownOp = (opcode == rvCorePkg::RType) || (opcode == rvCorePkg::ITypeLogic) ||
		(opcode == rvCorePkg::ITypeLoad) || (opcode == rvCorePkg::SType) ||
		(opcode == rvCorePkg::BType) || (opcode == rvCorePkg::JType);

	// an unsupported opcode parks the machine in decode
	assign halted = (state == rvCorePkg::Decode) && !knownOp;

	always_comb begin
		nextState = rvCorePkg::Fetch;
		case (state)
			rvCorePkg::Fetch: nextState = rvCorePkg::Decode;
			rvCorePkg::Decode: begin
				case (opcode)
					rvCorePkg::RType: nextState = rvCorePkg::ExecuteR;
					rvCorePkg::ITypeLogic: nextState = rvCorePkg::ExecuteI;
					rvCorePkg::ITypeLoad,
					rvCorePkg::SType: nextState = rvCorePkg::MemAdr;
					rvCorePkg::BType: nextState = rvCorePkg::BranchIfEq;
					rvCorePkg::JType: nextState = rvCorePkg::UncondJump;
					default: nextState = rvCorePkg::Decode;
				endcase
			end
			rvCorePkg::MemAdr: begin
				if (opcode == rvCorePkg::ITypeLoad)
					nextState = rvCorePkg::MemRead;
				else
					nextState = rvCorePkg::MemWrite;
			end
			rvCorePkg::ExecuteR,
			rvCorePkg::ExecuteI,
			rvCorePkg::UncondJump: nextState = rvCorePkg::AluWb;
			rvCorePkg::MemRead: nextState = rvCorePkg::MemWb;
			default: nextState = rvCorePkg::Fetch;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (state)
			rvCorePkg::Fetch: begin
				// read instruction at PC and compute PC+4 in the same cycle
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcA = rvCorePkg::SrcAPc;
				ctrl.aluSrcB = rvCorePkg::SrcBFour;
				ctrl.resultSrc = rvCorePkg::ResultAlu;
				ctrl.pcUpdate = 1'b1;
			end
			rvCorePkg::Decode: begin
				// target old PC + imm lands in ALU-out; also drives the bus,
				// so a halt word shows its own address
				ctrl.aluSrcA = rvCorePkg::SrcAOldPc;
				ctrl.aluSrcB = rvCorePkg::SrcBImm;
				ctrl.resultSrc = rvCorePkg::ResultAlu;
				ctrl.adrSrc = rvCorePkg::AdrResult;
			end
			rvCorePkg::ExecuteR: begin
				ctrl.aluSrcA = rvCorePkg::SrcARs1;
				ctrl.aluSrcB = rvCorePkg::SrcBRs2;
				ctrl.aluOp = rvCorePkg::AluOpRFunc;
			end
			rvCorePkg::ExecuteI: begin
				ctrl.aluSrcA = rvCorePkg::SrcARs1;
				ctrl.aluSrcB = rvCorePkg::SrcBImm;
				ctrl.aluOp = rvCorePkg::AluOpIFunc;
			end
			rvCorePkg::UncondJump: begin
				// jump to target while ALU-out picks up the link value
				ctrl.aluSrcA = rvCorePkg::SrcAOldPc;
				ctrl.aluSrcB = rvCorePkg::SrcBFour;
				ctrl.pcSrcJump = 1'b1;
				ctrl.pcUpdate = 1'b1;
			end
			rvCorePkg::MemAdr: begin
				ctrl.aluSrcA = rvCorePkg::SrcARs1;
				ctrl.aluSrcB = rvCorePkg::SrcBImm;
			end
			rvCorePkg::AluWb: begin
				ctrl.resultSrc = rvCorePkg::ResultAluOut;
				ctrl.regWrite = 1'b1;
			end
			rvCorePkg::MemWrite: begin
				ctrl.adrSrc = rvCorePkg::AdrResult;
				ctrl.resultSrc = rvCorePkg::ResultAluOut;
				ctrl.memWrite = 1'b1;
			end
			rvCorePkg::MemRead: begin
				ctrl.adrSrc = rvCorePkg::AdrResult;
				ctrl.resultSrc = rvCorePkg::ResultAluOut;
			end
			rvCorePkg::MemWb: begin
				ctrl.resultSrc = rvCorePkg::ResultData;
				ctrl.regWrite = 1'b1;
			end
			rvCorePkg::BranchIfEq: begin
				ctrl.aluSrcA = rvCorePkg::SrcARs1;
				ctrl.aluSrcB = rvCorePkg::SrcBRs2;
				ctrl.aluOp = rvCorePkg::AluOpSub;
				ctrl.pcSrcJump = 1'b1;
				ctrl.pcUpdate = zeroFlag;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// File: alu.sv
// ALU with its own operation decoder.
// Maps the controller's op class and the funct fields onto add, sub, and, or or slt.
`timescale 1ns/1ps

module alu (
	input rvCorePkg::aluOp_t aluOp,
	input logic [2:0] funct3,
	input logic funct7b5,
	input logic isRType,
	input rvCorePkg::word_t srcA,
	input rvCorePkg::word_t srcB,
	output rvCorePkg::word_t result,
	output logic zero
);

	rvCorePkg::aluCtrl_t aluCtrl;

	always_comb begin
		case (aluOp)
			rvCorePkg::AluOpAdd: aluCtrl = rvCorePkg::AluAdd;
			rvCorePkg::AluOpSub: aluCtrl = rvCorePkg::AluSub;
			default: begin
				case (funct3)
					// addi has no sub form, funct7 bit 5 counts only for R-type
					3'b000: aluCtrl = (isRType && funct7b5) ? rvCorePkg::AluSub : rvCorePkg::AluAdd;
					3'b010: aluCtrl = rvCorePkg::AluSlt;
					3'b110: aluCtrl = rvCorePkg::AluOr;
					3'b111: aluCtrl = rvCorePkg::AluAnd;
					default: aluCtrl = rvCorePkg::AluAdd;
				endcase
			end
		endcase
	end

	always_comb begin
		case (aluCtrl)
			rvCorePkg::AluSub: result = srcA - srcB;
			rvCorePkg::AluAnd: result = srcA & srcB;
			rvCorePkg::AluOr: result = srcA | srcB;
			rvCorePkg::AluSlt: result = rvCorePkg::word_t'($signed(srcA) < $signed(srcB));
			default: result = srcA + srcB;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: regFile.sv
// Integer register file, two combinational read ports and one synchronous write port.
`timescale 1ns/1ps
`include "rvCore_params.svh"

module regFile (
	input logic clk,
	input logic reset,
	input rvCorePkg::regIdx_t rs1,
	input rvCorePkg::regIdx_t rs2,
	input rvCorePkg::regIdx_t rd,
	input logic writeEnable,
	input rvCorePkg::word_t writeData,
	output rvCorePkg::word_t rd1,
	output rvCorePkg::word_t rd2
);

	rvCorePkg::word_t regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset)
			regs <= '{default: '0};
		else if (writeEnable && rd != '0)
			regs[rd] <= writeData;
	end

	// x0 reads as zero regardless of array contents
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: coreDatapath.sv
// Datapath of the multicycle core: PC, staging registers, ALU, register file and bus muxes.
// Every select and enable comes from the controller's struct.
`timescale 1ns/1ps
`include "rvCore_params.svh"

module coreDatapath (
	input logic clk,
	input logic reset,
	input rvCorePkg::ctrlSignals_t ctrl,
	input rvCorePkg::decodedInstr_t decoded,
	input rvCorePkg::word_t memReadData,
	output logic zeroFlag,
	output rvCorePkg::word_t memAddr,
	output rvCorePkg::word_t memWriteData
);

	rvCorePkg::word_t pc;
	rvCorePkg::word_t oldPc;
	rvCorePkg::word_t regA;
	rvCorePkg::word_t regB;
	rvCorePkg::word_t aluOut;
	rvCorePkg::word_t dataReg;
	rvCorePkg::word_t rd1;
	rvCorePkg::word_t rd2;
	rvCorePkg::word_t srcA;
	rvCorePkg::word_t srcB;
	rvCorePkg::word_t aluResult;
	rvCorePkg::word_t result;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (ctrl.pcUpdate)
			pc <= ctrl.pcSrcJump ? aluOut : result;
	end

	// staging registers load every cycle, old PC only with the instruction
	always_ff @(posedge clk) begin
		if (ctrl.irWrite)
			oldPc <= pc;
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
		dataReg <= memReadData;
	end

	regFile uRegFile (
		.clk(clk),
		.reset(reset),
		.rs1(decoded.rs1),
		.rs2(decoded.rs2),
		.rd(decoded.rd),
		.writeEnable(ctrl.regWrite),
		.writeData(result),
		.rd1(rd1),
		.rd2(rd2)
	);

	always_comb begin
		case (ctrl.aluSrcA)
			rvCorePkg::SrcAPc: srcA = pc;
			rvCorePkg::SrcAOldPc: srcA = oldPc;
			default: srcA = regA;
		endcase
		case (ctrl.aluSrcB)
			rvCorePkg::SrcBRs2: srcB = regB;
			rvCorePkg::SrcBImm: srcB = decoded.imm;
			default: srcB = rvCorePkg::word_t'(4);
		endcase
	end

	alu uAlu (
		.aluOp(ctrl.aluOp),
		.funct3(decoded.funct3),
		.funct7b5(decoded.funct7b5),
		.isRType(decoded.opcode == rvCorePkg::RType),
		.srcA(srcA),
		.srcB(srcB),
		.result(aluResult),
		.zero(zeroFlag)
	);

	always_comb begin
		case (ctrl.resultSrc)
			rvCorePkg::ResultAluOut: result = aluOut;
			rvCorePkg::ResultData: result = dataReg;
			default: result = aluResult;
		endcase
	end

	assign memAddr = (ctrl.adrSrc == rvCorePkg::AdrResult) ? result : pc;
	assign memWriteData = regB;

endmodule

// File: rvCoreTop.sv
// Top of the multicycle RV32I core on a single-cycle read memory bus.
// Writes happen at the rising edge with memWrite high, halted marks the end of a program.
`timescale 1ns/1ps

module rvCoreTop (
	input logic clk,
	input logic reset,
	input rvCorePkg::word_t memReadData,
	output rvCorePkg::word_t memAddr,
	output rvCorePkg::word_t memWriteData,
	output logic memWrite,
	output logic halted
);

	rvCorePkg::decodedInstr_t decoded;
	rvCorePkg::ctrlSignals_t ctrl;
	logic zeroFlag;

	instrDecoder uDecoder (
		.clk(clk),
		.reset(reset),
		.irWrite(ctrl.irWrite),
		.instrWord(memReadData),
		.decoded(decoded)
	);

	controlFsm uControl (
		.clk(clk),
		.reset(reset),
		.opcode(decoded.opcode),
		.zeroFlag(zeroFlag),
		.ctrl(ctrl),
		.halted(halted)
	);

	coreDatapath uDatapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.decoded(decoded),
		.memReadData(memReadData),
		.zeroFlag(zeroFlag),
		.memAddr(memAddr),
		.memWriteData(memWriteData)
	);

	assign memWrite = ctrl.memWrite;

endmodule

// File: tbRvCore.sv
// Testbench for the multicycle RV32I core: random programs from an LFSR, an ISA model,
// and per-cycle checks of the memory bus and the halted output against that model.
`timescale 1ns/1ps
`include "rvCore_params.svh"

module tbRvCore;

	localparam int clkPeriod = 40;
	localparam int numPrograms = 6;
	// random instructions per program, followed by seven stores and the halt word
	localparam int randLen = 40;
	localparam logic [31:0] lfsrSeed = 32'hd3024729;

	logic clk = 1'b0;
	logic reset;
	logic loadMem;
	rvCorePkg::word_t memReadData;
	rvCorePkg::word_t memAddr;
	rvCorePkg::word_t memWriteData;
	logic memWrite;
	logic halted;

	rvCorePkg::word_t lfsr;
	rvCorePkg::word_t image [256];
	rvCorePkg::word_t mem [256];
	rvCorePkg::word_t modelMem [256];
	int storeCycle [$];
	rvCorePkg::word_t storeAddr [$];
	rvCorePkg::word_t storeData [$];
	int expHalt;
	rvCorePkg::word_t haltPc;
	int valueErrors = 0;
	int otherErrors = 0;
	int budgetCycles = 0;
	int progIdx;

	rvCoreTop dut (
		.clk(clk),
		.reset(reset),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.halted(halted)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// memory reloads from the program image while loadMem is high
	always @(posedge clk) begin
		if (loadMem) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image[i];
		end else if (memWrite) begin
			mem[memAddr[9:2]] <= memWriteData;
		end
	end

	assign memReadData = loadMem ? '0 : mem[memAddr[9:2]];

	// taps 32, 22, 2, 1
	function automatic rvCorePkg::word_t randBits(input int n);
		rvCorePkg::word_t v;
		logic fb;
		v = '0;
		for (int b = 0; b < n; b++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [2:0] functFor(input int sel);
		case (sel)
			1: return 3'b111;
			2: return 3'b110;
			3: return 3'b010;
			default: return 3'b000;
		endcase
	endfunction

	function automatic rvCorePkg::word_t encR(input logic [2:0] f3, input logic sub,
		input rvCorePkg::regIdx_t rd, input rvCorePkg::regIdx_t rs1,
		input rvCorePkg::regIdx_t rs2);
		return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, rvCorePkg::RType};
	endfunction

	function automatic rvCorePkg::word_t encI(input rvCorePkg::opcode_t op,
		input logic [2:0] f3, input rvCorePkg::regIdx_t rd, input rvCorePkg::regIdx_t rs1,
		input rvCorePkg::word_t imm);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic rvCorePkg::word_t encS(input rvCorePkg::regIdx_t rs1,
		input rvCorePkg::regIdx_t rs2, input rvCorePkg::word_t imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvCorePkg::SType};
	endfunction

	function automatic rvCorePkg::word_t encB(input rvCorePkg::regIdx_t rs1,
		input rvCorePkg::regIdx_t rs2, input rvCorePkg::word_t imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvCorePkg::BType};
	endfunction

	function automatic rvCorePkg::word_t encJ(input rvCorePkg::regIdx_t rd,
		input rvCorePkg::word_t imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::JType};
	endfunction

	function automatic rvCorePkg::word_t aluRef(input logic [2:0] f3, input logic sub,
		input rvCorePkg::word_t a, input rvCorePkg::word_t b);
		case (f3)
			3'b111: return a & b;
			3'b110: return a | b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return sub ? a - b : a + b;
		endcase
	endfunction

	task automatic genProgram();
		int kind;
		int sel;
		rvCorePkg::regIdx_t rd;
		rvCorePkg::regIdx_t rs1;
		rvCorePkg::regIdx_t rs2;
		rvCorePkg::word_t off;
		for (int i = 0; i < 256; i++)
			image[i] = (32'(i) * 32'h0100_0193) ^ 32'hc3a5_5a3c;
		for (int i = 0; i < randLen; i++) begin
			kind = int'(randBits(4));
			rd = rvCorePkg::regIdx_t'(randBits(3));
			rs1 = rvCorePkg::regIdx_t'(randBits(3));
			rs2 = rvCorePkg::regIdx_t'(randBits(3));
			// forward targets only, at most four words ahead
			off = rvCorePkg::word_t'(4 * (1 + int'(randBits(2))));
			if (kind <= 4) begin
				sel = int'(randBits(3)) % 5;
				if (sel == 4)
					image[i] = encR(3'b000, 1'b1, rd, rs1, rs2);
				else
					image[i] = encR(functFor(sel), 1'b0, rd, rs1, rs2);
			end else if (kind <= 8) begin
				sel = int'(randBits(2));
				image[i] = encI(rvCorePkg::ITypeLogic, functFor(sel), rd, rs1, randBits(12));
			end else if (kind <= 10) begin
				image[i] = encI(rvCorePkg::ITypeLoad, 3'b010, rd, 5'd0,
					rvCorePkg::word_t'(256 + 4 * int'(randBits(6))));
			end else if (kind <= 12) begin
				image[i] = encS(5'd0, rs2, rvCorePkg::word_t'(256 + 4 * int'(randBits(6))));
			end else if (kind <= 14) begin
				image[i] = encB(rs1, rs2, off);
			end else begin
				image[i] = encJ(rd, off);
			end
		end
		// dump x1..x7 into their own slots, then the halt word
		for (int r = 1; r < 8; r++)
			image[randLen + r - 1] = encS(5'd0, rvCorePkg::regIdx_t'(r),
				rvCorePkg::word_t'(512 + 4 * r));
		image[randLen + 7] = '0;
	endtask

	task automatic runModel();
		rvCorePkg::word_t regs [32];
		rvCorePkg::word_t pc;
		rvCorePkg::word_t instr;
		rvCorePkg::word_t rs1v;
		rvCorePkg::word_t rs2v;
		rvCorePkg::word_t addr;
		rvCorePkg::word_t val;
		rvCorePkg::word_t immI;
		rvCorePkg::word_t immS;
		rvCorePkg::word_t immB;
		rvCorePkg::word_t immJ;
		rvCorePkg::word_t nextPc;
		int cycle;
		int cyc;
		logic wrEn;
		logic done;
		regs = '{default: '0};
		modelMem = image;
		storeCycle.delete();
		storeAddr.delete();
		storeData.delete();
		pc = `RESET_PC;
		cycle = 0;
		done = 1'b0;
		while (!done && cycle < 4096) begin
			instr = modelMem[pc[9:2]];
			rs1v = regs[instr[19:15]];
			rs2v = regs[instr[24:20]];
			immI = {{20{instr[31]}}, instr[31:20]};
			immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			nextPc = pc + 32'd4;
			wrEn = 1'b0;
			val = '0;
			cyc = 4;
			case (instr[6:0])
				rvCorePkg::RType: begin
					val = aluRef(instr[14:12], instr[30], rs1v, rs2v);
					wrEn = 1'b1;
				end
				rvCorePkg::ITypeLogic: begin
					val = aluRef(instr[14:12], 1'b0, rs1v, immI);
					wrEn = 1'b1;
				end
				rvCorePkg::ITypeLoad: begin
					addr = rs1v + immI;
					val = modelMem[addr[9:2]];
					wrEn = 1'b1;
					cyc = 5;
				end
				rvCorePkg::SType: begin
					addr = rs1v + immS;
					// bus write happens in the fourth cycle
					storeCycle.push_back(cycle + 3);
					storeAddr.push_back(addr);
					storeData.push_back(rs2v);
					modelMem[addr[9:2]] = rs2v;
				end
				rvCorePkg::BType: begin
					if (rs1v == rs2v)
						nextPc = pc + immB;
					cyc = 3;
				end
				rvCorePkg::JType: begin
					val = pc + 32'd4;
					wrEn = 1'b1;
					nextPc = pc + immJ;
				end
				default: done = 1'b1;
			endcase
			if (done) begin
				// halt word fetch, then decode raises halted
				expHalt = cycle + 1;
				haltPc = pc;
			end else begin
				if (wrEn && instr[11:7] != 5'd0)
					regs[instr[11:7]] = val;
				pc = nextPc;
				cycle += cyc;
			end
		end
	endtask

	task automatic checkValue(input string name, input rvCorePkg::word_t got,
		input rvCorePkg::word_t exp);
		assert (got === exp)
		else begin
			$display("CHECK FAILED %s got 0x%08h expected 0x%08h (program %0d, %0t)",
				name, got, exp, progIdx, $time);
			valueErrors++;
		end
	endtask

	task automatic holdReset();
		reset = 1'b1;
		loadMem = 1'b1;
		repeat (5) begin
			@(negedge clk);
			checkValue("memWrite", 32'(memWrite), 32'd0);
			checkValue("memAddr", memAddr, `RESET_PC);
		end
		reset = 1'b0;
		loadMem = 1'b0;
	endtask

	// sample k sees cycle k after reset release; cycle 0 is the first fetch
	task automatic runProgram(input int limit);
		int wr;
		int seen;
		logic expWrite;
		wr = 0;
		seen = 0;
		for (int k = 1; k <= limit; k++) begin
			@(negedge clk);
			expWrite = (wr < storeCycle.size()) && (storeCycle[wr] == k);
			if (memWrite === 1'b1)
				seen++;
			checkValue("memWrite", 32'(memWrite), 32'(expWrite));
			if (expWrite) begin
				checkValue("memAddr", memAddr, storeAddr[wr]);
				checkValue("memWriteData", memWriteData, storeData[wr]);
				wr++;
			end
			checkValue("halted", 32'(halted), 32'(k == expHalt));
		end
		if (limit == expHalt) begin
			checkValue("memAddr", memAddr, haltPc);
			assert (seen == storeCycle.size())
			else begin
				$display("program %0d showed %0d bus writes where %0d stores were expected",
					progIdx, seen, storeCycle.size());
				otherErrors++;
			end
		end
	endtask

	initial begin
		int total;
		reset = 1'b1;
		loadMem = 1'b1;
		progIdx = 0;
		// dry pass over all programs to size the watchdog
		lfsr = lfsrSeed;
		total = 0;
		for (int p = 0; p < numPrograms; p++) begin
			genProgram();
			runModel();
			total += expHalt;
		end
		budgetCycles = 2 * total + numPrograms * 20 + 100;
		lfsr = lfsrSeed;
		for (int p = 0; p < numPrograms; p++) begin
			progIdx = p;
			genProgram();
			runModel();
			// first run is cut off halfway by a reset, second one runs to the halt
			holdReset();
			runProgram(expHalt / 2);
			holdReset();
			runProgram(expHalt);
		end
		$display("summary: %0d value mismatches, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		wait (budgetCycles > 0);
		#(budgetCycles * clkPeriod);
		$display("watchdog expired after %0d cycles in program %0d", budgetCycles, progIdx);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
rvCorePkg.sv
instrDecoder.sv
controlFsm.sv
alu.sv
regFile.sv
coreDatapath.sv
rvCoreTop.sv
tbRvCore.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tbRvCore -o simTb
	./obj_dir/simTb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
